/* list.f */
+incdir+hw
hw/rv32_pkg.sv
hw/decode_if.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/rv32_decode_unit.sv
test/tb_clock_gen.sv
test/decode_unit_properties.sv
test/tb_decode_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the decode unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_decode_unit -o sim \
    || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/sim +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1

/* test/tb_decode_unit.sv */
`include "rv32_macros.svh"

module tb_decode_unit;
    import rv32_pkg::*;

    localparam int TIMEOUT = 20;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        dec_valid;
    logic [6:0]  op;
    instr_fmt_t  fmt;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [9:0]  func;
    logic [31:0] imm;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] pc_out;
    logic        illegal;
    int          timeout_errors = 0;
    logic [6:0]  known_ops [9];

    tb_clock_gen #(.PERIOD(4)) clock_inst (.clk(clk));

    rv32_decode_unit rv32_decode_unit_inst (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .instr(instr), .pc(pc),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .dec_valid(dec_valid),
        .op(op), .fmt(fmt), .rs1(rs1), .rs2(rs2), .rd(rd), .func(func), .imm(imm),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .pc_out(pc_out), .illegal(illegal)
    );

    function automatic bit is_known(input logic [6:0] opc);
        for (int i = 0; i < 9; i++) begin
            if (known_ops[i] == opc) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic [6:0] unknown_op();
        logic [6:0] c;
        for (int k = 0; k < 64; k++) begin
            c = 7'($urandom());
            if (!is_known(c)) begin
                return c;
            end
        end
        return 7'b0001111;  // Fence.
    endfunction

    function automatic logic [31:0] random_word(input logic [6:0] opc);
        logic [31:0] w;
        w      = $urandom();
        w[6:0] = opc;
        return w;
    endfunction

    task automatic go_idle();
        in_valid = 1'b0;
        wb_en    = 1'b0;
    endtask

    // Optional write-back aimed at one of the sources.
    task automatic drive_instr(input logic [31:0] word, input bit fwd);
        in_valid = 1'b1;
        instr    = word;
        pc       = $urandom();
        wb_en    = fwd;
        wb_rd    = ($urandom_range(1) != 0) ? word[19:15] : word[24:20];
        wb_data  = $urandom();
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!dec_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!dec_valid) begin
            timeout_errors++;
            $display("Timeout at %0t: no dec_valid within %0d cycles", $time, TIMEOUT);
        end
    endtask

    task automatic send_one(input logic [31:0] word, input bit fwd);
        drive_instr(word, fwd);
        @(negedge clk);
        go_idle();
        wait_valid();
    endtask

    initial begin
        int assert_errors;
        rst_n    = 1'b0;
        in_valid = 1'b1;  // Offered during reset, must not come out.
        instr    = '0;
        pc       = '0;
        wb_en    = 1'b0;
        wb_rd    = '0;
        wb_data  = '0;
        known_ops = '{`OP_R, `OP_I, `OP_I_LOAD, `OP_I_JALR, `OP_S, `OP_B,
                      `OP_U_LUI, `OP_U_AUIPC, `OP_J};
        void'($urandom(32'h4c9a277f));
        repeat (16) @(negedge clk);
        rst_n    = 1'b1;
        in_valid = 1'b0;
        repeat (2) @(negedge clk);

        // Load every register, x0 included.
        for (int r = 0; r < `REG_COUNT; r++) begin
            wb_en   = 1'b1;
            wb_rd   = 5'(r);
            wb_data = $urandom();
            @(negedge clk);
        end
        go_idle();
        @(negedge clk);

        for (int i = 0; i < 9; i++) begin
            for (int k = 0; k < 8; k++) begin
                send_one(random_word(known_ops[i]), k[0]);
            end
        end
        send_one({7'b0100000, 5'd7, 5'd3, 3'b101, 5'd9, `OP_I}, 1'b0);  // srai.
        send_one({12'hff0, 5'd4, 3'b001, 5'd6, `OP_I_LOAD}, 1'b1);
        send_one({7'b0, 5'd0, 5'd0, 3'b000, 5'd5, `OP_R}, 1'b1);  // Write x0, read x0.

        for (int k = 0; k < 6; k++) begin
            send_one(random_word(unknown_op()), k[0]);
        end
        send_one(random_word(7'b0001111), 1'b0);
        send_one(random_word(7'b1110011), 1'b1);

        // Back-to-back issue with write-back traffic.
        for (int k = 0; k < 24; k++) begin
            drive_instr(random_word(known_ops[$urandom_range(8)]), 1'b1);
            if (k % 3 == 0) begin
                wb_rd = 5'($urandom());
            end
            @(negedge clk);
        end
        go_idle();
        wait_valid();
        repeat (3) @(negedge clk);

        assert_errors = rv32_decode_unit_inst.props_inst.fail_count;
        $display("Checks done: %0d assertion errors, %0d timeout errors",
                 assert_errors, timeout_errors);
        if (assert_errors + timeout_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* test/decode_unit_properties.sv */
`include "rv32_macros.svh"

module decode_unit_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_valid,
    input logic [31:0]          instr,
    input logic [31:0]          pc,
    input logic                 wb_en,
    input logic [4:0]           wb_rd,
    input logic [31:0]          wb_data,
    input logic                 dec_valid,
    input logic [6:0]           op,
    input rv32_pkg::instr_fmt_t fmt,
    input logic [4:0]           rs1,
    input logic [4:0]           rs2,
    input logic [4:0]           rd,
    input logic [9:0]           func,
    input logic [31:0]          imm,
    input logic [31:0]          rs1_val,
    input logic [31:0]          rs2_val,
    input logic [31:0]          pc_out,
    input logic                 illegal
);
    import rv32_pkg::*;

    int       fail_count = 0;
    word_t    shadow [`REG_COUNT];
    decoded_t exp_now;
    decoded_t exp_q;

    // Sign extension of the low bits of v.
    function automatic word_t sext(input word_t v, input int bits);
        return $signed(v << (32 - bits)) >>> (32 - bits);
    endfunction

    function automatic decoded_t expect_fields(input logic [31:0] w);
        decoded_t   d;
        logic [6:0] opc;
        logic [2:0] f3;
        d   = '0;
        opc = w[6:0];
        f3  = w[14:12];
        d.op  = opc;
        d.fmt = FMT_NONE;
        if (opc == `OP_R) begin
            d.fmt  = FMT_R;
            d.rs1  = w[19:15];
            d.rs2  = w[24:20];
            d.rd   = w[11:7];
            d.func = {w[31:25], f3};
        end else if (opc == `OP_I || opc == `OP_I_LOAD || opc == `OP_I_JALR) begin
            d.fmt = FMT_I;
            d.rs1 = w[19:15];
            d.rd  = w[11:7];
            d.func = {7'b0, f3};
            d.imm  = sext(32'(w[31:20]), 12);
            if (opc == `OP_I && (f3 == 3'b001 || f3 == 3'b101)) begin
                d.func = {w[31:25], f3};  // Shift keeps funct7.
                d.imm  = {27'b0, w[24:20]};
            end
        end else if (opc == `OP_S || opc == `OP_B) begin
            d.fmt  = (opc == `OP_S) ? FMT_S : FMT_B;
            d.rs1  = w[19:15];
            d.rs2  = w[24:20];
            d.func = {7'b0, f3};
            if (opc == `OP_S) begin
                d.imm = sext(32'({w[31:25], w[11:7]}), 12);
            end else begin
                d.imm = sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
            end
        end else if (opc == `OP_U_LUI || opc == `OP_U_AUIPC) begin
            d.fmt = FMT_U;
            d.rd  = w[11:7];
            d.imm = {w[31:12], 12'b0};
        end else if (opc == `OP_J) begin
            d.fmt = FMT_J;
            d.rd  = w[11:7];
            d.imm = sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
        end else begin
            d.illegal = 1'b1;
        end
        return d;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow[i] <= '0;
            end
        end else if (wb_en && wb_rd != 5'd0) begin
            shadow[wb_rd] <= wb_data;
        end
    end

    // Expected bundle for the instruction presented this cycle.
    always_comb begin
        exp_now = expect_fields(instr);
        if (exp_now.rs1 == 5'd0) begin
            exp_now.rs1_val = '0;
        end else if (wb_en && wb_rd == exp_now.rs1) begin
            exp_now.rs1_val = wb_data;  // Same-cycle write-back.
        end else begin
            exp_now.rs1_val = shadow[exp_now.rs1];
        end
        if (exp_now.rs2 == 5'd0) begin
            exp_now.rs2_val = '0;
        end else if (wb_en && wb_rd == exp_now.rs2) begin
            exp_now.rs2_val = wb_data;
        end else begin
            exp_now.rs2_val = shadow[exp_now.rs2];
        end
        exp_now.pc = pc;
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            exp_q <= exp_now;
        end
    end

    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !dec_valid)
        else begin
            $error("** Error at %0t: dec_valid high right after reset", $time);
            fail_count++;
        end

    a_valid_rise: assert property (@(posedge clk) disable iff (!rst_n) in_valid |=> dec_valid)
        else begin
            $error("** Error at %0t: dec_valid missing one cycle after in_valid", $time);
            fail_count++;
        end

    a_valid_fall: assert property (@(posedge clk) disable iff (!rst_n) !in_valid |=> !dec_valid)
        else begin
            $error("** Error at %0t: dec_valid high without in_valid", $time);
            fail_count++;
        end

    a_fields: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> (op == exp_q.op && fmt == exp_q.fmt && rs1 == exp_q.rs1
                       && rs2 == exp_q.rs2 && rd == exp_q.rd && illegal == exp_q.illegal))
        else begin
            $error("** Error at %0t: op, fmt, index or illegal mismatch", $time);
            fail_count++;
        end

    a_func_imm: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> (func == exp_q.func && imm == exp_q.imm))
        else begin
            $error("** Error at %0t: func %h or imm %h wrong", $time, func, imm);
            fail_count++;
        end

    a_values: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> (rs1_val == exp_q.rs1_val && rs2_val == exp_q.rs2_val))
        else begin
            $error("** Error at %0t: source values %h %h wrong", $time, rs1_val, rs2_val);
            fail_count++;
        end

    a_pc: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> (pc_out == exp_q.pc))
        else begin
            $error("** Error at %0t: pc_out %h wrong", $time, pc_out);
            fail_count++;
        end

endmodule

bind rv32_decode_unit decode_unit_properties props_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .instr     (instr),
    .pc        (pc),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .dec_valid (dec_valid),
    .op        (op),
    .fmt       (fmt),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .func      (func),
    .imm       (imm),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .pc_out    (pc_out),
    .illegal   (illegal)
);

/* test/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;  // Half period per phase.
        end
    end

endmodule

/* hw/rv32_decode_unit.sv */
`include "rv32_macros.svh"

module rv32_decode_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [31:0]          instr,
    input  logic [`XLEN-1:0]     pc,
    input  logic                 wb_en,
    input  logic [4:0]           wb_rd,
    input  logic [`XLEN-1:0]     wb_data,
    output logic                 dec_valid,
    output logic [6:0]           op,
    output rv32_pkg::instr_fmt_t fmt,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [4:0]           rd,
    output logic [9:0]           func,
    output logic [`XLEN-1:0]     imm,
    output logic [`XLEN-1:0]     rs1_val,
    output logic [`XLEN-1:0]     rs2_val,
    output logic [`XLEN-1:0]     pc_out,
    output logic                 illegal
);
    import rv32_pkg::*;

    dec_if     dec_bus ();
    rf_read_if rf_bus ();
    decoded_t  result;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec_bus.producer)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .rd_port (rf_bus.responder)
    );

    decode_stage u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .pc        (pc),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .dec       (dec_bus.consumer),
        .rf        (rf_bus.requester),
        .out       (result),
        .dec_valid (dec_valid)
    );

    // Flatten the registered bundle.
    assign op      = result.op;
    assign fmt     = result.fmt;
    assign rs1     = result.rs1;
    assign rs2     = result.rs2;
    assign rd      = result.rd;
    assign func    = result.func;
    assign imm     = result.imm;
    assign rs1_val = result.rs1_val;
    assign rs2_val = result.rs2_val;
    assign pc_out  = result.pc;
    assign illegal = result.illegal;

endmodule

/* hw/decode_stage.sv */
module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  rv32_pkg::word_t    pc,
    input  logic               wb_en,
    input  rv32_pkg::reg_idx_t wb_rd,
    input  rv32_pkg::word_t    wb_data,
    dec_if.consumer            dec,
    rf_read_if.requester       rf,
    output rv32_pkg::decoded_t out,
    output logic               dec_valid
);
    import rv32_pkg::*;

    logic     fwd1;
    logic     fwd2;
    word_t    src1;
    word_t    src2;
    decoded_t bundle;

    assign rf.raddr1 = dec.rs1;
    assign rf.raddr2 = dec.rs2;

    // Write-back of this cycle is not yet in the register file.
    assign fwd1 = wb_en && (wb_rd != '0) && (wb_rd == dec.rs1);
    assign fwd2 = wb_en && (wb_rd != '0) && (wb_rd == dec.rs2);

    assign src1 = fwd1 ? wb_data : rf.rdata1;
    assign src2 = fwd2 ? wb_data : rf.rdata2;

    always_comb begin
        bundle.op      = dec.op;
        bundle.fmt     = dec.fmt;
        bundle.rs1     = dec.rs1;
        bundle.rs2     = dec.rs2;
        bundle.rd      = dec.rd;
        bundle.func    = dec.func;
        bundle.imm     = dec.imm;
        bundle.rs1_val = src1;
        bundle.rs2_val = src2;
        bundle.pc      = pc;
        bundle.illegal = dec.illegal;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // Payload holds while no new instruction arrives.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out <= bundle;
        end
    end

endmodule

/* hw/reg_file.sv */
`include "rv32_macros.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_en,
    input  rv32_pkg::reg_idx_t wb_rd,
    input  rv32_pkg::word_t    wb_data,
    rf_read_if.responder      rd_port
);
    import rv32_pkg::*;

    word_t regs [`REG_COUNT];

    // Single write port, x0 is never written.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Reads are combinational.
    always_comb begin
        if (rd_port.raddr1 == '0) begin
            rd_port.rdata1 = '0;
        end else begin
            rd_port.rdata1 = regs[rd_port.raddr1];
        end

        if (rd_port.raddr2 == '0) begin
            rd_port.rdata2 = '0;
        end else begin
            rd_port.rdata2 = regs[rd_port.raddr2];
        end
    end

endmodule

/* hw/instr_decoder.sv */
`include "rv32_macros.svh"

module instr_decoder (
    input logic [31:0] instr,
    dec_if.producer    dec
);
    import rv32_pkg::*;

    opcode_t  opcode;
    reg_idx_t f_rs1;
    reg_idx_t f_rs2;
    reg_idx_t f_rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_shift;
    word_t    imm_i;
    word_t    imm_sh;
    word_t    imm_s;
    word_t    imm_b;
    word_t    imm_u;
    word_t    imm_j;

    // Raw fields sit at fixed positions in every format.
    assign opcode = instr[6:0];
    assign f_rs1  = instr[19:15];
    assign f_rs2  = instr[24:20];
    assign f_rd   = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign is_shift = (funct3 == `F3_SLL) || (funct3 == `F3_SRL_SRA);

    // Immediates of each format.
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_sh = {27'b0, instr[24:20]};   // Shift amount only.
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{19{instr[31]}},
                     instr[31],
                     instr[7],
                     instr[30:25],
                     instr[11:8],
                     1'b0};
    assign imm_u  = {instr[31:12], 12'h000};
    assign imm_j  = {{11{instr[31]}},
                     instr[31],
                     instr[19:12],
                     instr[20],
                     instr[30:21],
                     1'b0};

    always_comb begin
        // Opcode is passed through even when it is unknown.
        dec.op      = opcode;
        dec.fmt     = FMT_NONE;
        dec.rs1     = '0;
        dec.rs2     = '0;
        dec.rd      = '0;
        dec.func    = '0;
        dec.imm     = '0;
        dec.illegal = 1'b0;

        case (opcode)
            `OP_R: begin
                dec.fmt  = FMT_R;
                dec.rs1  = f_rs1;
                dec.rs2  = f_rs2;
                dec.rd   = f_rd;
                dec.func = {funct7, funct3};
            end
            `OP_I, `OP_I_LOAD, `OP_I_JALR: begin
                dec.fmt = FMT_I;
                dec.rs1 = f_rs1;
                dec.rd  = f_rd;
                if (is_shift) begin
                    dec.func = {funct7, funct3};
                    dec.imm  = imm_sh;
                end else begin
                    dec.func = {7'b0, funct3};
                    dec.imm  = imm_i;
                end
            end
            `OP_S: begin
                dec.fmt  = FMT_S;
                dec.rs1  = f_rs1;
                dec.rs2  = f_rs2;
                dec.func = {7'b0, funct3};
                dec.imm  = imm_s;
            end
            `OP_B: begin
                dec.fmt  = FMT_B;
                dec.rs1  = f_rs1;
                dec.rs2  = f_rs2;
                dec.func = {7'b0, funct3};
                dec.imm  = imm_b;
            end
            `OP_U_LUI, `OP_U_AUIPC: begin
                dec.fmt = FMT_U;
                dec.rd  = f_rd;
                dec.imm = imm_u;
            end
            `OP_J: begin
                dec.fmt = FMT_J;
                dec.rd  = f_rd;
                dec.imm = imm_j;
            end
            default: begin
                dec.illegal = 1'b1;  // CSR and fence land here too.
            end
        endcase

        // Shifts only decode on OP-IMM, not on loads or JALR.
        if ((opcode == `OP_I_LOAD) || (opcode == `OP_I_JALR)) begin
            dec.func = {7'b0, funct3};
            dec.imm  = imm_i;
        end
    end

endmodule

/* hw/decode_if.sv */
// Decoder fields, valid for the instruction currently presented.
interface dec_if;
    import rv32_pkg::*;

    opcode_t    op;
    instr_fmt_t fmt;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    func_t      func;
    word_t      imm;
    logic       illegal;

    modport producer (
        output op, fmt, rs1, rs2, rd, func, imm, illegal
    );

    modport consumer (
        input op, fmt, rs1, rs2, rd, func, imm, illegal
    );
endinterface

// Two combinational read ports of the register file.
interface rf_read_if;
    import rv32_pkg::*;

    reg_idx_t raddr1;
    reg_idx_t raddr2;
    word_t    rdata1;
    word_t    rdata2;

    modport requester (
        output raddr1, raddr2,
        input  rdata1, rdata2
    );

    modport responder (
        input  raddr1, raddr2,
        output rdata1, rdata2
    );
endinterface

/* hw/rv32_pkg.sv */
`include "rv32_macros.svh"

package rv32_pkg;

    // Common widths.
    typedef logic [`XLEN-1:0]                word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0]   reg_idx_t;
    typedef logic [6:0]                      opcode_t;
    typedef logic [9:0]                      func_t;

    // Instruction formats.
    typedef enum logic [2:0] {
        FMT_R    = 3'd0,
        FMT_I    = 3'd1,
        FMT_S    = 3'd2,
        FMT_B    = 3'd3,
        FMT_U    = 3'd4,
        FMT_J    = 3'd5,
        FMT_NONE = 3'd6
    } instr_fmt_t;

    // Registered result of the decode stage.
    typedef struct packed {
        opcode_t    op;
        instr_fmt_t fmt;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        func_t      func;     // funct7 over funct3, or funct3 alone.
        word_t      imm;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      pc;
        logic       illegal;
    } decoded_t;

endpackage

/* hw/rv32_macros.svh */
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

// Core sizes.
`define XLEN      32
`define REG_COUNT 32

// Opcodes, grouped by instruction format.
`define OP_R       7'b0110011  // OP, also carries the M extension.
`define OP_I       7'b0010011  // OP-IMM.
`define OP_I_LOAD  7'b0000011
`define OP_I_JALR  7'b1100111
`define OP_S       7'b0100011
`define OP_B       7'b1100011
`define OP_U_LUI   7'b0110111
`define OP_U_AUIPC 7'b0010111  // Same layout as LUI.
`define OP_J       7'b1101111

// funct3 values that mark the immediate shifts.
`define F3_SLL     3'b001
`define F3_SRL_SRA 3'b101

`endif
